// ==== source/cpu_pkg.sv ====
// Shared widths, opcodes and record types of the execution slice.
// Words keep the panel bit order with bit 0 as the most significant bit.

package cpu_pkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------

	localparam int WORD_BITS = 16;
	localparam int REG_COUNT = 8;
	localparam int REG_BITS = $clog2(REG_COUNT);
	localparam int IMM_BITS = 6; // short constant T

	typedef logic [0:WORD_BITS-1] word_t;
	typedef logic [REG_BITS-1:0] reg_idx_t;

	// ----------------------------------------
	// opcodes, word bits 0..3
	// ----------------------------------------

	typedef enum logic [3:0] {
		OP_LW = 4'd0, // load sign-extended T
		OP_MV = 4'd1, // copy rC
		OP_AW = 4'd2,
		OP_AC = 4'd3, // add with carry
		OP_SW = 4'd4,
		OP_NR = 4'd5,
		OP_OR = 4'd6,
		OP_ER = 4'd7, // clear bits of A set in C
		OP_XR = 4'd8
	} op_e;

	typedef struct packed {
		logic z; // zero
		logic m; // minus, result bit 0
		logic v; // signed overflow
		logic c; // carry out of the sum
	} flags_t;

	// decoded instruction, decode -> execute
	typedef struct packed {
		logic valid;
		op_e op;
		reg_idx_t ra;
		reg_idx_t rc;
		word_t imm;
		logic wr_reg;
		logic arith; // sets z m v c
		logic logic_op; // sets z m only
		logic illegal;
	} dec_t;

	// executed instruction, execute -> result
	typedef struct packed {
		logic valid;
		logic illegal;
		logic wr_reg;
		reg_idx_t ra;
		word_t value;
		flags_t flags_new; // complete next flag value
	} res_t;

endpackage

// ==== source/cpu_decode.sv ====
// Instruction register stage. One word is captured per start pulse.
// Codes 9..15 are flagged illegal and never write a register.

`timescale 1ns/1ps

module cpu_decode (
	input logic __clk,
	input logic arst_n,
	input cpu_pkg::word_t kl,
	input logic start,
	output cpu_pkg::dec_t dec
);

	cpu_pkg::dec_t dec_next;

	// ----------------------------------------
	// field split and classification
	// ----------------------------------------

	always_comb begin
		dec_next = '0;
		dec_next.valid = 1'b1;
		dec_next.op = cpu_pkg::op_e'(kl[0:3]);
		dec_next.ra = kl[4:6]; // destination and first operand
		dec_next.rc = kl[7:9];
		// T is signed, bit 10 is its sign
		dec_next.imm = {{(cpu_pkg::WORD_BITS - cpu_pkg::IMM_BITS){kl[10]}}, kl[10:15]};

		case (dec_next.op)
			cpu_pkg::OP_LW, cpu_pkg::OP_MV: begin
				dec_next.wr_reg = 1'b1; // flags untouched
			end
			cpu_pkg::OP_AW, cpu_pkg::OP_AC, cpu_pkg::OP_SW: begin
				dec_next.wr_reg = 1'b1;
				dec_next.arith = 1'b1;
			end
			cpu_pkg::OP_NR, cpu_pkg::OP_OR, cpu_pkg::OP_ER, cpu_pkg::OP_XR: begin
				dec_next.wr_reg = 1'b1;
				dec_next.logic_op = 1'b1;
			end
			default: begin
				dec_next.illegal = 1'b1;
			end
		endcase
	end

	// ----------------------------------------
	// instruction register
	// ----------------------------------------

	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			dec <= '0;
		end else if (start) begin
			dec <= dec_next;
		end else begin
			dec.valid <= 1'b0; // fields hold, slot empty
		end
	end

	// an illegal word must never reach the register file
	a_illegal_no_write: assert property (
		@(posedge __clk) disable iff (!arst_n)
		dec.valid && dec.illegal |-> !dec.wr_reg
	);

endmodule

// ==== source/cpu_execute.sv ====
// Arithmetic stage with single-level forwarding from the pending result.
// Only one result can be pending, so one bypass path covers all hazards.

`timescale 1ns/1ps

module cpu_execute (
	input logic __clk,
	input logic arst_n,
	input cpu_pkg::dec_t dec,
	input cpu_pkg::word_t rd_a_data,
	input cpu_pkg::word_t rd_c_data,
	input cpu_pkg::flags_t flags,
	output cpu_pkg::reg_idx_t rd_a,
	output cpu_pkg::reg_idx_t rd_c,
	output cpu_pkg::res_t res
);

	logic res_legal;
	logic fwd_a;
	logic fwd_c;
	cpu_pkg::word_t op_a;
	cpu_pkg::word_t op_c;
	cpu_pkg::flags_t cur_flags;
	cpu_pkg::word_t add_b; // second adder input, inverted for SW
	logic carry_in;
	logic [cpu_pkg::WORD_BITS:0] sum;
	cpu_pkg::word_t sum_word;
	cpu_pkg::word_t value;
	cpu_pkg::flags_t flags_new;

	assign rd_a = dec.ra;
	assign rd_c = dec.rc;

	// ----------------------------------------
	// operand select
	// ----------------------------------------

	assign res_legal = res.valid && !res.illegal;
	assign fwd_a = res_legal && res.wr_reg && (res.ra == dec.ra);
	assign fwd_c = res_legal && res.wr_reg && (res.ra == dec.rc);

	assign op_a = fwd_a ? res.value : rd_a_data;
	assign op_c = fwd_c ? res.value : rd_c_data;
	// whole flag word, so kept v and c also come from the pending result
	assign cur_flags = res_legal ? res.flags_new : flags;

	// ----------------------------------------
	// adder
	// ----------------------------------------

	always_comb begin
		add_b = op_c;
		carry_in = 1'b0;
		if (dec.op == cpu_pkg::OP_SW) begin
			add_b = ~op_c; // A + ~C + 1
			carry_in = 1'b1;
		end else if (dec.op == cpu_pkg::OP_AC) begin
			carry_in = cur_flags.c;
		end
	end

	assign sum = {1'b0, op_a} + {1'b0, add_b} + {{cpu_pkg::WORD_BITS{1'b0}}, carry_in};
	assign sum_word = sum[cpu_pkg::WORD_BITS-1:0];

	// ----------------------------------------
	// result and flags
	// ----------------------------------------

	always_comb begin
		case (dec.op)
			cpu_pkg::OP_LW: value = dec.imm;
			cpu_pkg::OP_MV: value = op_c;
			cpu_pkg::OP_AW, cpu_pkg::OP_AC, cpu_pkg::OP_SW: value = sum_word;
			cpu_pkg::OP_NR: value = op_a & op_c;
			cpu_pkg::OP_OR: value = op_a | op_c;
			cpu_pkg::OP_ER: value = op_a & ~op_c;
			cpu_pkg::OP_XR: value = op_a ^ op_c;
			default: value = '0; // illegal, never written
		endcase

		flags_new = cur_flags; // LW and MV keep everything
		if (dec.arith || dec.logic_op) begin
			flags_new.z = (value == '0);
			flags_new.m = value[0];
		end
		if (dec.arith) begin
			flags_new.v = (op_a[0] == add_b[0]) && (sum_word[0] != op_a[0]);
			flags_new.c = sum[cpu_pkg::WORD_BITS];
		end
	end

	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			res <= '0;
		end else begin
			res.valid <= dec.valid;
			res.illegal <= dec.illegal;
			res.wr_reg <= dec.wr_reg;
			res.ra <= dec.ra;
			res.value <= value;
			res.flags_new <= flags_new;
		end
	end

	a_res_follows_dec: assert property (
		@(posedge __clk) disable iff (!arst_n)
		1'b1 |=> (res.valid == $past(dec.valid))
	);

endmodule

// ==== source/cpu_result.sv ====
// General registers, flag register and panel outputs.
// An illegal result only pulses ill and leaves all state alone.

`timescale 1ns/1ps

module cpu_result (
	input logic __clk,
	input logic arst_n,
	input cpu_pkg::res_t res,
	input cpu_pkg::reg_idx_t rd_a,
	input cpu_pkg::reg_idx_t rd_c,
	output cpu_pkg::word_t rd_a_data,
	output cpu_pkg::word_t rd_c_data,
	output cpu_pkg::flags_t flags,
	output cpu_pkg::word_t w,
	output logic p0,
	output logic ill
);

	cpu_pkg::word_t regs [cpu_pkg::REG_COUNT];
	logic commit;

	assign commit = res.valid && !res.illegal;

	// ----------------------------------------
	// register file
	// ----------------------------------------

	// asynchronous read ports for the execute stage
	assign rd_a_data = regs[rd_a];
	assign rd_c_data = regs[rd_c];

	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < cpu_pkg::REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (commit && res.wr_reg) begin
			regs[res.ra] <= res.value;
		end
	end

	// ----------------------------------------
	// flags, display and pulses
	// ----------------------------------------

	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			flags <= '0;
			w <= '0;
			p0 <= 1'b0;
			ill <= 1'b0;
		end else begin
			p0 <= commit; // one cycle per finished word
			ill <= res.valid && res.illegal;
			if (commit) begin
				flags <= res.flags_new;
				w <= res.value;
			end
		end
	end

	a_p0_ill_exclusive: assert property (
		@(posedge __clk) disable iff (!arst_n)
		!(p0 && ill)
	);

endmodule

// ==== source/cpu.sv ====
// Three-stage execution slice driven from the panel key register.
// No memory, bus or interrupts. Each start gives p0 or ill two clocks later.

`timescale 1ns/1ps

module cpu (
	input logic __clk,
	input logic arst_n,
	input cpu_pkg::word_t kl,
	input logic start,
	output cpu_pkg::word_t w,
	output cpu_pkg::flags_t flags,
	output logic p0,
	output logic ill
);

	cpu_pkg::dec_t dec;
	cpu_pkg::res_t res;
	cpu_pkg::reg_idx_t rd_a;
	cpu_pkg::reg_idx_t rd_c;
	cpu_pkg::word_t rd_a_data;
	cpu_pkg::word_t rd_c_data;

	// ----------------------------------------
	// pipeline
	// ----------------------------------------

	cpu_decode i_decode (
		.__clk(__clk),
		.arst_n(arst_n),
		.kl(kl),
		.start(start),
		.dec(dec)
	);

	cpu_execute i_execute (
		.__clk(__clk),
		.arst_n(arst_n),
		.dec(dec),
		.rd_a_data(rd_a_data),
		.rd_c_data(rd_c_data),
		.flags(flags), // committed flags, bypassed inside
		.rd_a(rd_a),
		.rd_c(rd_c),
		.res(res)
	);

	cpu_result i_result (
		.__clk(__clk),
		.arst_n(arst_n),
		.res(res),
		.rd_a(rd_a),
		.rd_c(rd_c),
		.rd_a_data(rd_a_data),
		.rd_c_data(rd_c_data),
		.flags(flags),
		.w(w),
		.p0(p0),
		.ill(ill)
	);

endmodule

// ==== verification/cpu_tb.sv ====
// Self-checking testbench. A reference model predicts each retired word and
// concurrent assertions compare w, flags and the p0/ill pulses with it.

`timescale 1ns/1ps

module cpu_tb;

	localparam int DIRECTED_WORDS = 42;
	localparam int RANDOM_WORDS = 300;
	localparam int TOTAL_WORDS = DIRECTED_WORDS + RANDOM_WORDS;
	localparam int TIMEOUT_CYCLES = 2 * TOTAL_WORDS + 50;

	logic clk;
	logic arst_n;
	cpu_pkg::word_t kl;
	logic start;
	cpu_pkg::word_t w;
	cpu_pkg::flags_t flags;
	logic p0;
	logic ill;

	// model state, bit 15 here is word bit 0
	logic [15:0] m_regs [cpu_pkg::REG_COUNT];
	logic [15:0] m_w;
	cpu_pkg::flags_t m_flags;
	cpu_pkg::word_t exp_w [TOTAL_WORDS]; // indexed by issue order
	cpu_pkg::flags_t exp_flags [TOTAL_WORDS];
	logic exp_ill [TOTAL_WORDS];
	int issue_idx = 0;
	int ret_idx = 0;
	int cycles = 0;
	int value_errors = 0;
	int other_errors = 0;
	int seed = 77581;
	string test_name = "reset";

	cpu i_dut (
		.__clk(clk),
		.arst_n(arst_n),
		.kl(kl),
		.start(start),
		.w(w),
		.flags(flags),
		.p0(p0),
		.ill(ill)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ----------------------------------------
	// reporting and checks
	// ----------------------------------------

	function automatic void report_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		value_errors++;
		$display("[FAIL] %s, %s: expected %h, actual %h", test_name, what, expected, actual);
	endfunction

	function automatic void report_event(input string what);
		other_errors++;
		$display("error in %s: %s", test_name, what);
	endfunction

	a_reset_state: assert property (@(posedge clk) disable iff (!arst_n)
		issue_idx == 0 |-> (w == '0 && flags == '0 && !p0 && !ill))
		else report_value("outputs after reset", '0,
			{$sampled(w), $sampled(flags), $sampled(p0), $sampled(ill)});

	// sampled three edges later, the pulse itself rises on the second
	a_latency: assert property (@(posedge clk) disable iff (!arst_n)
		(p0 || ill) == $past(start, 3))
		else report_event("p0 or ill did not follow start by two clocks");

	a_kind: assert property (@(posedge clk) disable iff (!arst_n)
		(p0 || ill) |-> (ill == exp_ill[ret_idx]))
		else report_value("ill", exp_ill[$sampled(ret_idx)], $sampled(ill));

	a_w: assert property (@(posedge clk) disable iff (!arst_n)
		(p0 || ill) |-> (w == exp_w[ret_idx]))
		else report_value("w", exp_w[$sampled(ret_idx)], $sampled(w));

	a_flags: assert property (@(posedge clk) disable iff (!arst_n)
		(p0 || ill) |-> (flags == exp_flags[ret_idx]))
		else report_value("flags zmvc", exp_flags[$sampled(ret_idx)], $sampled(flags));

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (p0 || ill) begin
			ret_idx <= ret_idx + 1; // one expectation consumed
		end
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, %0d of %0d words retired",
				cycles, ret_idx, issue_idx);
			$display("Result: FAILED");
			$finish;
		end
	end

	// ----------------------------------------
	// reference model
	// ----------------------------------------

	task automatic model_step(input logic [15:0] word);
		logic [3:0] op;
		logic [15:0] a;
		logic [15:0] c;
		logic [15:0] r;
		int sres;
		int ures;
		int cin;
		op = word[15:12];
		a = m_regs[word[11:9]];
		c = m_regs[word[8:6]];
		r = '0;
		cin = (op == 4'd3) ? int'(m_flags.c) : 0;
		exp_ill[issue_idx] = (op > 4'd8);
		if (op <= 4'd8) begin
			case (op)
				4'd0: r = {{10{word[5]}}, word[5:0]};
				4'd1: r = c;
				4'd2, 4'd3: begin
					sres = int'($signed(a)) + int'($signed(c)) + cin;
					ures = int'(a) + int'(c) + cin;
					r = ures[15:0];
					m_flags.v = (sres > 32767) || (sres < -32768);
					m_flags.c = (ures > 65535);
				end
				4'd4: begin
					sres = int'($signed(a)) - int'($signed(c));
					r = a - c;
					m_flags.v = (sres > 32767) || (sres < -32768);
					m_flags.c = (a >= c); // no borrow
				end
				4'd5: r = a & c;
				4'd6: r = a | c;
				4'd7: r = a & ~c;
				default: r = a ^ c;
			endcase
			if (op >= 4'd2) begin
				m_flags.z = (r == 16'h0000);
				m_flags.m = r[15];
			end
			m_regs[word[11:9]] = r;
			m_w = r;
		end
		exp_w[issue_idx] = m_w;
		exp_flags[issue_idx] = m_flags;
		issue_idx++;
	endtask

	// ----------------------------------------
	// stimulus
	// ----------------------------------------

	function automatic logic [15:0] encode(input logic [3:0] op, input logic [2:0] ra,
			input logic [2:0] rc, input logic [5:0] t);
		return {op, ra, rc, t};
	endfunction

	task automatic issue(input logic [15:0] word);
		@(negedge clk);
		kl = word;
		start = 1'b1;
		model_step(word);
	endtask

	task automatic idle();
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic drain();
		idle();
		while (ret_idx != issue_idx) begin
			idle();
		end
	endtask

	task automatic run_random();
		int r;
		for (int n = 0; n < RANDOM_WORDS; n++) begin
			r = $random(seed);
			issue(r[15:0]);
			if (r[18:16] == 3'd0) begin
				repeat (r[20:19] + 1) idle(); // gap, otherwise a run
			end
		end
	endtask

	initial begin
		arst_n = 1'b0;
		kl = '0;
		start = 1'b0;
		m_regs = '{default: 16'h0000};
		m_w = '0;
		m_flags = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		test_name = "load constants";
		issue(encode(cpu_pkg::OP_LW, 3'd1, 3'd0, 6'd5));
		issue(encode(cpu_pkg::OP_LW, 3'd2, 3'd0, 6'h3d)); // -3
		issue(encode(cpu_pkg::OP_LW, 3'd3, 3'd0, 6'h20)); // -32
		drain();

		test_name = "forwarding";
		issue(encode(cpu_pkg::OP_LW, 3'd1, 3'd0, 6'd7));
		issue(encode(cpu_pkg::OP_AW, 3'd1, 3'd1, 6'd0));
		issue(encode(cpu_pkg::OP_AW, 3'd1, 3'd1, 6'd0));
		drain();

		test_name = "arithmetic flags";
		issue(encode(cpu_pkg::OP_LW, 3'd2, 3'd0, 6'd1));
		repeat (15) issue(encode(cpu_pkg::OP_AW, 3'd2, 3'd2, 6'd0)); // ends at 0x8000
		issue(encode(cpu_pkg::OP_LW, 3'd4, 3'd0, 6'd10));
		issue(encode(cpu_pkg::OP_SW, 3'd3, 3'd3, 6'd0));
		issue(encode(cpu_pkg::OP_AC, 3'd4, 3'd4, 6'd0));
		drain();

		test_name = "logic ops";
		issue(encode(cpu_pkg::OP_MV, 3'd6, 3'd2, 6'd0));
		issue(encode(cpu_pkg::OP_AW, 3'd6, 3'd2, 6'd0)); // sets v and c
		issue(encode(cpu_pkg::OP_LW, 3'd5, 3'd0, 6'd15));
		issue(encode(cpu_pkg::OP_LW, 3'd7, 3'd0, 6'h33));
		issue(encode(cpu_pkg::OP_NR, 3'd5, 3'd7, 6'd0));
		issue(encode(cpu_pkg::OP_OR, 3'd5, 3'd7, 6'd0));
		issue(encode(cpu_pkg::OP_ER, 3'd5, 3'd7, 6'd0));
		issue(encode(cpu_pkg::OP_XR, 3'd5, 3'd7, 6'd0));
		drain();

		test_name = "illegal opcodes";
		for (int op = 9; op < 16; op++) begin
			issue(encode(4'(op), 3'd1, 3'd5, 6'h2a));
		end
		issue(encode(cpu_pkg::OP_MV, 3'd0, 3'd1, 6'd0));
		issue(encode(cpu_pkg::OP_MV, 3'd0, 3'd5, 6'd0));
		drain();

		test_name = "random words";
		run_random();
		drain();

		$display("checks failed: %0d value, %0d other; words issued %0d, retired %0d",
			value_errors, other_errors, issue_idx, ret_idx);
		if (value_errors == 0 && other_errors == 0 && ret_idx == TOTAL_WORDS) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
source/cpu_pkg.sv
source/cpu_decode.sv
source/cpu_execute.sv
source/cpu_result.sv
source/cpu.sv
verification/cpu_tb.sv

// ==== Makefile ====
# Verilator flow for the cpu execution slice

LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert -f verilog.f --top-module cpu

sim:
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module cpu_tb -Mdir obj_dir
	./obj_dir/Vcpu_tb | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
